/* hw/sensor_params.svh */
`ifndef SENSOR_PARAMS_SVH
`define SENSOR_PARAMS_SVH

// Clock dividers, all in system clock cycles
`define SPI_DIV     4     // Half SCK period
`define BAUD_DIV    16    // One UART bit
`define REFRESH_DIV 64    // One display digit
`define SAMPLE_DIV  4096  // Start to start of two reads

// ADXL362 register read command
`define CMD_READ    8'h0B

// Low byte of each axis data pair
`define ADDR_X      8'h0E
`define ADDR_Y      8'h10
`define ADDR_Z      8'h12

`endif

/* hw/sensor_pkg.sv */
package sensor_pkg;

   // One accelerometer reading, high data byte on top
   typedef logic [15:0] sample_t;

   // One byte on SPI or UART
   typedef logic [7:0] byte_t;

   // Switch code for the axis, 0 X, 1 Y, 2 and 3 Z
   typedef logic [1:0] axis_t;

   // Read sequence of the controller
   typedef enum logic [2:0] {
      IDLE,    // Waiting for sample timer
      CMD,     // Read command byte on the wire
      ADDR,    // Register address on the wire
      RD_LO,   // First dummy, low data byte returns
      RD_HI,   // Second dummy, high data byte returns
      PUBLISH, // Sample register, valid strobe, display load
      TX_HI,   // UART high byte
      TX_LO    // UART low byte
   } ctrl_state_e;

endpackage

/* hw/spi_if.sv */
`timescale 1ns/1ns

// One SPI byte transfer between the controller and the SPI master
interface spi_if;
   import sensor_pkg::*;

   logic  start;    // One-cycle request
   byte_t tx_byte;  // Byte to shift out
   logic  hold_cs;  // Keep nCS low after this byte
   byte_t rx_byte;  // Byte shifted in, valid with done
   logic  done;     // One-cycle completion

   modport ctrl (
      output start, tx_byte, hold_cs,
      input  rx_byte, done
   );

   modport master (
      input  start, tx_byte, hold_cs,
      output rx_byte, done
   );

endinterface

/* hw/spi_master.sv */
`timescale 1ns/1ns
`include "sensor_params.svh"

// Mode 0 byte shifter for the ADXL362, MSB first
module spi_master #(
   parameter int SPI_DIV = `SPI_DIV
) (
   input  logic  clk_in,
   input  logic  rst_n_i,
   spi_if.master bus,
   output logic  sck_o,
   output logic  ncs_o,
   output logic  mosi_o,
   input  logic  miso_i
);
   import sensor_pkg::*;

   localparam int DW = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
   localparam logic [DW-1:0] DIV_MAX = DW'(SPI_DIV - 1);

   logic [DW-1:0] div_q;     // Half period counter
   logic [3:0]    edge_q;    // SCK edge index, 16 per byte
   logic          busy_q;
   logic          hold_q;    // hold_cs of the byte in flight
   logic          tick;      // SCK toggles this cycle
   logic          last_edge; // Eighth falling edge
   logic          accept;
   byte_t         tx_sh_q;
   byte_t         rx_sh_q;

   assign tick      = busy_q && (div_q == DIV_MAX);
   assign last_edge = tick && (edge_q == 4'd15);
   // A new byte may start in the done cycle itself
   assign accept    = bus.start && (!busy_q || last_edge);

   assign bus.done    = last_edge;
   assign bus.rx_byte = rx_sh_q;
   assign mosi_o      = tx_sh_q[7]; // Set up before the first rising edge

   always_ff @(posedge clk_in or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         div_q  <= '0;
         edge_q <= 4'd0;
         hold_q <= 1'b0;
         sck_o  <= 1'b0; // SCK idles low
         ncs_o  <= 1'b1;
      end else if (accept) begin
         busy_q <= 1'b1;
         div_q  <= '0;
         edge_q <= 4'd0;
         hold_q <= bus.hold_cs;
         sck_o  <= 1'b0;
         ncs_o  <= 1'b0; // Falls the cycle after start
      end else if (tick) begin
         div_q  <= '0;
         edge_q <= edge_q + 4'd1;
         sck_o  <= ~sck_o;
         if (edge_q == 4'd15) begin
            busy_q <= 1'b0;
            if (!hold_q)
               ncs_o <= 1'b1; // Frame ends, one cycle after done
         end
      end else if (busy_q) begin
         div_q <= div_q + DW'(1);
      end
   end

   // Shift registers, SCK level before the toggle tells the edge
   always_ff @(posedge clk_in) begin
      if (accept)
         tx_sh_q <= bus.tx_byte;
      else if (tick && sck_o)
         tx_sh_q <= {tx_sh_q[6:0], 1'b0}; // Falling edge, next bit out
      else if (tick)
         rx_sh_q <= {rx_sh_q[6:0], miso_i}; // Rising edge, sample MISO
   end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ns
`include "sensor_params.svh"

// 8N1 transmitter, LSB first, no receive side
module uart_tx #(
   parameter int BAUD_DIV = `BAUD_DIV
) (
   input  logic                clk_in,
   input  logic                rst_n_i,
   input  logic                start_i,
   input  sensor_pkg::byte_t   data_i,
   output logic                done_o,
   output logic                tx_o
);

   localparam int BW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
   localparam logic [BW-1:0] BAUD_MAX = BW'(BAUD_DIV - 1);

   logic [BW-1:0] baud_q;  // Cycles within current bit
   logic [3:0]    bit_q;   // Start, 8 data, stop
   logic [9:0]    frame_q; // Bit 0 is on the line
   logic          busy_q;
   logic          bit_end;
   logic          last_bit;

   assign bit_end  = busy_q && (baud_q == BAUD_MAX);
   assign last_bit = bit_end && (bit_q == 4'd9); // End of stop bit
   assign done_o   = last_bit;
   assign tx_o     = frame_q[0];

   always_ff @(posedge clk_in or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q  <= 1'b0;
         baud_q  <= '0;
         bit_q   <= 4'd0;
         frame_q <= '1; // Line idles high
      end else if (start_i && (!busy_q || last_bit)) begin
         busy_q  <= 1'b1;
         baud_q  <= '0;
         bit_q   <= 4'd0;
         frame_q <= {1'b1, data_i, 1'b0}; // Stop, data, start
      end else if (bit_end) begin
         baud_q  <= '0;
         bit_q   <= bit_q + 4'd1;
         frame_q <= {1'b1, frame_q[9:1]}; // Ones fill in behind
         if (bit_q == 4'd9)
            busy_q <= 1'b0;
      end else if (busy_q) begin
         baud_q <= baud_q + BW'(1);
      end
   end

endmodule

/* hw/seg_display.sv */
`timescale 1ns/1ns
`include "sensor_params.svh"

// Four-digit hex display, active-low anodes and cathodes
module seg_display #(
   parameter int REFRESH_DIV = `REFRESH_DIV
) (
   input  logic                clk_in,
   input  logic                rst_n_i,
   input  logic                load_i,
   input  sensor_pkg::sample_t value_i,
   output logic [3:0]          anode_o,
   output logic [7:0]          cathode_o
);
   import sensor_pkg::*;

   localparam int RW = (REFRESH_DIV > 1) ? $clog2(REFRESH_DIV) : 1;
   localparam logic [RW-1:0] REFRESH_MAX = RW'(REFRESH_DIV - 1);

   sample_t       value_q;   // Value on show
   logic [RW-1:0] refresh_q;
   logic [1:0]    digit_q;   // 0 is the lowest nibble
   logic [3:0]    nibble;
   logic [6:0]    seg_on;    // gfedcba, active high

   assign nibble = value_q[{digit_q, 2'b00} +: 4];

   // Hex glyphs, lower-case b and d
   always_comb begin
      case (nibble)
         4'h0:    seg_on = 7'h3F;
         4'h1:    seg_on = 7'h06;
         4'h2:    seg_on = 7'h5B;
         4'h3:    seg_on = 7'h4F;
         4'h4:    seg_on = 7'h66;
         4'h5:    seg_on = 7'h6D;
         4'h6:    seg_on = 7'h7D;
         4'h7:    seg_on = 7'h07;
         4'h8:    seg_on = 7'h7F;
         4'h9:    seg_on = 7'h6F;
         4'hA:    seg_on = 7'h77;
         4'hB:    seg_on = 7'h7C; // b
         4'hC:    seg_on = 7'h39;
         4'hD:    seg_on = 7'h5E; // d
         4'hE:    seg_on = 7'h79;
         default: seg_on = 7'h71; // F
      endcase
   end

   always_ff @(posedge clk_in or negedge rst_n_i) begin
      if (!rst_n_i) begin
         value_q   <= '0;
         refresh_q <= '0;
         digit_q   <= 2'd0;
         anode_o   <= 4'hF; // All digits dark
         cathode_o <= 8'hFF;
      end else begin
         if (load_i)
            value_q <= value_i;
         if (refresh_q == REFRESH_MAX) begin
            refresh_q <= '0;
            digit_q   <= digit_q + 2'd1; // Next digit
         end else begin
            refresh_q <= refresh_q + RW'(1);
         end
         anode_o   <= ~(4'b0001 << digit_q); // One anode low
         cathode_o <= {1'b1, ~seg_on};       // Decimal point off
      end
   end

endmodule

/* hw/sensor_ctrl.sv */
`timescale 1ns/1ns
`include "sensor_params.svh"

// Sample timer and read sequencer for one ADXL362 axis
module sensor_ctrl #(
   parameter int SAMPLE_DIV = `SAMPLE_DIV
) (
   input  logic                clk_in,
   input  logic                rst_n_i,
   input  sensor_pkg::axis_t   axis_i,
   spi_if.ctrl                 spi,
   output logic                tx_start_o,
   output sensor_pkg::byte_t   tx_data_o,
   input  logic                tx_done_i,
   output sensor_pkg::sample_t sample_o,
   output logic                sample_valid_o
);
   import sensor_pkg::*;

   localparam int TW = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
   localparam logic [TW-1:0] TIMER_MAX = TW'(SAMPLE_DIV - 1);

   ctrl_state_e   state_q;
   logic [TW-1:0] timer_q;
   logic          expire_q; // Timer wrapped last cycle
   axis_t         axis_q;   // Axis of the read in flight
   byte_t         addr;
   byte_t         lo_q;
   byte_t         hi_q;

   always_comb begin
      case (axis_q)
         2'd0:    addr = `ADDR_X;
         2'd1:    addr = `ADDR_Y;
         default: addr = `ADDR_Z; // 3 reads Z as well
      endcase
   end

   // Next byte starts in the done cycle of the previous one
   always_comb begin
      spi.start   = 1'b0;
      spi.tx_byte = `CMD_READ;
      spi.hold_cs = 1'b1;
      case (state_q)
         IDLE:  spi.start = expire_q;
         CMD: begin
            spi.start   = spi.done;
            spi.tx_byte = addr;
         end
         ADDR: begin
            spi.start   = spi.done;
            spi.tx_byte = 8'h00; // First dummy
         end
         RD_LO: begin
            spi.start   = spi.done;
            spi.tx_byte = 8'h00; // Second dummy
            spi.hold_cs = 1'b0;  // Last byte of the frame
         end
         default: ;
      endcase
   end

   // UART bytes, high first
   assign tx_start_o = (state_q == PUBLISH) || ((state_q == TX_HI) && tx_done_i);
   assign tx_data_o  = (state_q == PUBLISH) ? hi_q : lo_q;

   always_ff @(posedge clk_in or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q        <= IDLE;
         timer_q        <= '0;
         expire_q       <= 1'b0;
         sample_o       <= '0;
         sample_valid_o <= 1'b0;
      end else begin
         timer_q        <= (timer_q == TIMER_MAX) ? '0 : timer_q + TW'(1);
         expire_q       <= (timer_q == TIMER_MAX); // Free running, dropped if busy
         sample_valid_o <= 1'b0;
         case (state_q)
            IDLE:    if (expire_q) state_q <= CMD;
            CMD:     if (spi.done) state_q <= ADDR;
            ADDR:    if (spi.done) state_q <= RD_LO;
            RD_LO:   if (spi.done) state_q <= RD_HI;
            RD_HI:   if (spi.done) state_q <= PUBLISH;
            PUBLISH: begin
               sample_o       <= {hi_q, lo_q};
               sample_valid_o <= 1'b1; // Also the display load
               state_q        <= TX_HI;
            end
            TX_HI:   if (tx_done_i) state_q <= TX_LO;
            default: if (tx_done_i) state_q <= IDLE;
         endcase
      end
   end

   // Axis and data bytes
   always_ff @(posedge clk_in) begin
      if (state_q == IDLE && expire_q)
         axis_q <= axis_i;
      if (state_q == RD_LO && spi.done)
         lo_q <= spi.rx_byte;
      if (state_q == RD_HI && spi.done)
         hi_q <= spi.rx_byte;
   end

endmodule

/* hw/sensor_top.sv */
`timescale 1ns/1ns

// Accelerometer readout, SPI in, UART and display out
module sensor_top (
   input  logic        clk_in,
   input  logic        rst_n_i,
   input  logic [1:0]  axis_i,    // Switches
   input  logic        miso_i,
   output logic        sck_o,
   output logic        ncs_o,
   output logic        mosi_o,
   output logic        tx_o,
   output logic [3:0]  anode_o,
   output logic [7:0]  cathode_o,
   output logic [15:0] sample_o,
   output logic        sample_valid_o
);
   import sensor_pkg::*;

   byte_t tx_data;
   logic  tx_start;
   logic  tx_done;

   spi_if spi_bus ();   // Controller to SPI master

   sensor_ctrl ctrl_i (
      .clk_in         (clk_in),
      .rst_n_i        (rst_n_i),
      .axis_i         (axis_i),
      .spi            (spi_bus.ctrl),
      .tx_start_o     (tx_start),
      .tx_data_o      (tx_data),
      .tx_done_i      (tx_done),
      .sample_o       (sample_o),
      .sample_valid_o (sample_valid_o)
   );

   spi_master spi_i (
      .clk_in  (clk_in),
      .rst_n_i (rst_n_i),
      .bus     (spi_bus.master),
      .sck_o   (sck_o),
      .ncs_o   (ncs_o),
      .mosi_o  (mosi_o),
      .miso_i  (miso_i)
   );

   uart_tx uart_i (
      .clk_in  (clk_in),
      .rst_n_i (rst_n_i),
      .start_i (tx_start),
      .data_i  (tx_data),
      .done_o  (tx_done),
      .tx_o    (tx_o)
   );

   // Valid strobe doubles as display load
   seg_display disp_i (
      .clk_in    (clk_in),
      .rst_n_i   (rst_n_i),
      .load_i    (sample_valid_o),
      .value_i   (sample_o),
      .anode_o   (anode_o),
      .cathode_o (cathode_o)
   );

endmodule

/* testbench/adxl_model.sv */
`timescale 1ns/1ns

// ADXL362 stand-in, answers a register read with two data bytes from the testbench
module adxl_model (
   input  logic              sck_i,
   input  logic              ncs_i,
   input  logic              mosi_i,
   output logic              miso_o,
   input  sensor_pkg::byte_t lo_byte_i,   // Returned on the third byte
   input  sensor_pkg::byte_t hi_byte_i,   // Returned on the fourth byte
   output logic [31:0]       frame_o,     // MOSI bytes, first one on top
   output int                byte_cnt_o,  // Bytes in the current frame
   output int                frame_cnt_o  // Frames closed by nCS rising
);
   import sensor_pkg::*;

   byte_t in_sh   = '0;
   byte_t out_sh  = '0;
   int    bit_cnt = 0;
   logic  sck_d   = 1'b0;
   logic  ncs_d   = 1'b1;

   assign miso_o = out_sh[7]; // MSB first

   // Command and address slots answer zero
   function automatic byte_t reply(input int idx);
      case (idx)
         2:       return lo_byte_i;
         3:       return hi_byte_i;
         default: return 8'h00;
      endcase
   endfunction

   // Edges found by comparing with the last seen levels
   always @(sck_i or ncs_i) begin
      if (ncs_d && !ncs_i) begin
         byte_cnt_o = 0; // Frame opens
         bit_cnt    = 0;
         out_sh     = reply(0);
      end else if (!ncs_d && ncs_i) begin
         frame_cnt_o = frame_cnt_o + 1;
      end else if (!ncs_i && sck_i && !sck_d) begin
         in_sh   = {in_sh[6:0], mosi_i}; // Mode 0 samples on rising SCK
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8) begin
            frame_o    = {frame_o[23:0], in_sh};
            byte_cnt_o = byte_cnt_o + 1;
            bit_cnt    = 0;
         end
      end else if (!ncs_i && !sck_i && sck_d) begin
         if (bit_cnt == 0)
            out_sh = reply(byte_cnt_o); // First bit of next byte
         else
            out_sh = {out_sh[6:0], 1'b0};
      end
      ncs_d = ncs_i;
      sck_d = sck_i;
   end

endmodule

/* testbench/tb_sensor.sv */
`timescale 1ns/1ns
`include "sensor_params.svh"

// Testbench for sensor_top with a behavioral ADXL362 on the SPI pins
module tb_sensor;
   import sensor_pkg::*;

   localparam int NUM_PAT = 9;
   localparam int BAUD    = `BAUD_DIV;
   localparam int REFRESH = `REFRESH_DIV;
   localparam int SAMPLE  = `SAMPLE_DIV;

   logic        clk_in = 1'b0;
   logic        rst_n;
   axis_t       axis;
   byte_t       model_lo;
   byte_t       model_hi;
   logic        sck;
   logic        ncs;
   logic        mosi;
   logic        miso;
   logic        tx;
   logic [3:0]  anode;
   logic [7:0]  cathode;
   sample_t     sample;
   logic        sample_valid;
   logic [31:0] spi_frame;
   int          spi_bytes;
   int          spi_frames;

   logic [15:0] pat_mem [0:4*NUM_PAT-1]; // Axis, lo, hi, expected per test

   int    mismatch_cnt = 0;
   int    fail_cnt     = 0;    // Main flow
   int    mon_fail_cnt = 0;    // Line monitors
   logic  timed_out    = 1'b0; // A wait ran out of cycles
   byte_t uart_q [$];          // Every byte seen on tx
   logic  rx_busy      = 1'b0;
   int    rx_cnt       = 0;
   byte_t rx_bits      = '0;

   always #20 clk_in = ~clk_in; // 40 ns period

   sensor_top dut_i (
      .clk_in         (clk_in),
      .rst_n_i        (rst_n),
      .axis_i         (axis),
      .miso_i         (miso),
      .sck_o          (sck),
      .ncs_o          (ncs),
      .mosi_o         (mosi),
      .tx_o           (tx),
      .anode_o        (anode),
      .cathode_o      (cathode),
      .sample_o       (sample),
      .sample_valid_o (sample_valid)
   );

   adxl_model adxl_i (
      .sck_i       (sck),
      .ncs_i       (ncs),
      .mosi_i      (mosi),
      .miso_o      (miso),
      .lo_byte_i   (model_lo),
      .hi_byte_i   (model_hi),
      .frame_o     (spi_frame),
      .byte_cnt_o  (spi_bytes),
      .frame_cnt_o (spi_frames)
   );

   // UART receiver and SCK idle check on the falling clock edge
   always @(negedge clk_in) begin
      if (rst_n && ncs && sck) begin
         mon_fail_cnt = mon_fail_cnt + 1;
         $display("Error at %0t ns: SCK is high while nCS is high", $time);
      end
      if (rst_n) begin
         if (!rx_busy) begin
            if (!tx) begin
               rx_busy = 1'b1; // Start bit edge
               rx_cnt  = 0;
            end
         end else begin
            rx_cnt = rx_cnt + 1;
            if (rx_cnt % BAUD == BAUD / 2) begin // Middle of a bit
               if (rx_cnt / BAUD == 0) begin
                  if (tx)
                     rx_busy = 1'b0; // Glitch only
               end else if (rx_cnt / BAUD <= 8) begin
                  rx_bits = {tx, rx_bits[7:1]}; // LSB arrives first
               end else begin
                  if (!tx) begin
                     mon_fail_cnt = mon_fail_cnt + 1;
                     $display("Error at %0t ns: UART stop bit is low", $time);
                  end
                  uart_q.push_back(rx_bits);
                  rx_busy = 1'b0;
               end
            end
         end
      end
   end

   // Low-byte register address per switch code
   function automatic byte_t addr_for(input axis_t a);
      case (a)
         2'd0:    return 8'h0E;
         2'd1:    return 8'h10;
         default: return 8'h12; // 3 is Z too
      endcase
   endfunction

   // Active-low cathode pattern with DP off in bit 7
   function automatic byte_t glyph_for(input logic [3:0] nib);
      case (nib)
         4'h0:    return 8'hC0;
         4'h1:    return 8'hF9;
         4'h2:    return 8'hA4;
         4'h3:    return 8'hB0;
         4'h4:    return 8'h99;
         4'h5:    return 8'h92;
         4'h6:    return 8'h82;
         4'h7:    return 8'hF8;
         4'h8:    return 8'h80;
         4'h9:    return 8'h90;
         4'hA:    return 8'h88;
         4'hB:    return 8'h83; // b
         4'hC:    return 8'hC6;
         4'hD:    return 8'hA1; // d
         4'hE:    return 8'h86;
         default: return 8'h8E;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      mismatch_cnt = mismatch_cnt + 1;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
   endtask

   task automatic end_run();
      int others;
      others = fail_cnt + mon_fail_cnt;
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, others);
      if (mismatch_cnt == 0 && others == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   task automatic wait_valid();
      int n;
      n = 0;
      while (sample_valid !== 1'b1 && n < SAMPLE + 1000) begin
         @(negedge clk_in);
         n = n + 1;
      end
      if (sample_valid !== 1'b1) begin
         $display("Timeout at %0t ns: sample_valid_o never rose", $time);
         fail_cnt  = fail_cnt + 1;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_uart(input int base);
      int n;
      n = 0;
      while (uart_q.size() < base + 2 && n < 25 * BAUD) begin
         @(negedge clk_in);
         n = n + 1;
      end
      if (uart_q.size() < base + 2) begin
         $display("Timeout at %0t ns: fewer than two UART bytes after a sample", $time);
         fail_cnt  = fail_cnt + 1;
         timed_out = 1'b1;
      end
   endtask

   // Checks four digit periods in a row at their middles
   task automatic scan_display(input sample_t shown);
      logic [3:0] start_anode;
      logic [3:0] seen;
      logic [3:0] nib;
      int         n;
      int         d;
      int         k;
      repeat (5 * REFRESH) @(negedge clk_in); // Past one full scan
      start_anode = anode;
      n = 0;
      while (anode == start_anode && n < 2 * REFRESH) begin
         @(negedge clk_in);
         n = n + 1;
      end
      if (anode == start_anode) begin
         $display("Timeout at %0t ns: display anodes stopped scanning", $time);
         fail_cnt  = fail_cnt + 1;
         timed_out = 1'b1;
         return;
      end
      seen = 4'h0;
      for (k = 0; k < 4; k++) begin
         repeat (REFRESH / 2) @(negedge clk_in);
         case (anode)
            4'hE:    d = 0;
            4'hD:    d = 1;
            4'hB:    d = 2;
            4'h7:    d = 3;
            default: d = -1;
         endcase
         if (d < 0) begin
            fail_cnt = fail_cnt + 1;
            $display("Error at %0t ns: anode_o %b does not select one digit", $time, anode);
         end else begin
            seen[d] = 1'b1;
            nib     = shown[d*4 +: 4];
            if (cathode !== glyph_for(nib))
               report_mismatch("cathode_o", 32'(cathode), 32'(glyph_for(nib)));
         end
         repeat (REFRESH - REFRESH / 2) @(negedge clk_in);
      end
      if (seen !== 4'hF) begin
         fail_cnt = fail_cnt + 1;
         $display("Error at %0t ns: four digit periods did not cover all digits", $time);
      end
   endtask

   initial begin
      int      p;
      int      i;
      int      base;
      int      frames;
      axis_t   p_axis;
      byte_t   p_lo;
      byte_t   p_hi;
      sample_t p_exp;
      rst_n    = 1'b0;
      axis     = 2'd0;
      model_lo = 8'h00;
      model_hi = 8'h00;
      $readmemh("testbench/sensor_patterns.txt", pat_mem);

      // Outputs held at their reset values
      repeat (16) begin
         @(negedge clk_in);
         if (ncs !== 1'b1)
            report_mismatch("ncs_o", 32'(ncs), 32'(1));
         if (sck !== 1'b0)
            report_mismatch("sck_o", 32'(sck), 32'(0));
         if (tx !== 1'b1)
            report_mismatch("tx_o", 32'(tx), 32'(1));
         if (sample_valid !== 1'b0)
            report_mismatch("sample_valid_o", 32'(sample_valid), 32'(0));
         if (anode !== 4'hF)
            report_mismatch("anode_o", 32'(anode), 32'(4'hF));
         if (sample !== 16'h0000)
            report_mismatch("sample_o", 32'(sample), 32'(0));
      end
      rst_n = 1'b1;

      for (p = 0; p < NUM_PAT; p++) begin
         p_axis = pat_mem[4*p][1:0];
         p_lo   = pat_mem[4*p+1][7:0];
         p_hi   = pat_mem[4*p+2][7:0];
         p_exp  = pat_mem[4*p+3];
         @(negedge clk_in);
         axis     = p_axis; // Set while the controller idles
         model_lo = p_lo;
         model_hi = p_hi;
         base     = uart_q.size();
         frames   = spi_frames;

         // Bus quiet until the first timer expiry
         if (p == 0) begin
            for (i = 0; i < SAMPLE - 64; i++) begin
               @(negedge clk_in);
               if (ncs !== 1'b1)
                  report_mismatch("ncs_o", 32'(ncs), 32'(1));
               if (sck !== 1'b0)
                  report_mismatch("sck_o", 32'(sck), 32'(0));
               if (tx !== 1'b1)
                  report_mismatch("tx_o", 32'(tx), 32'(1));
               if (sample_valid !== 1'b0)
                  report_mismatch("sample_valid_o", 32'(sample_valid), 32'(0));
            end
         end

         wait_valid();
         if (timed_out)
            break;
         if (sample !== p_exp)
            report_mismatch("sample_o", 32'(sample), 32'(p_exp));

         // One frame of four bytes under a single low nCS
         if (spi_frames != frames + 1) begin
            fail_cnt = fail_cnt + 1;
            $display("Error at %0t ns: %0d SPI frames seen for one sample",
                     $time, spi_frames - frames);
         end
         if (spi_bytes != 4) begin
            fail_cnt = fail_cnt + 1;
            $display("Error at %0t ns: SPI frame had %0d bytes instead of 4",
                     $time, spi_bytes);
         end
         if (spi_frame[31:24] !== 8'h0B)
            report_mismatch("mosi_o command", 32'(spi_frame[31:24]), 32'(8'h0B));
         if (spi_frame[23:16] !== addr_for(p_axis))
            report_mismatch("mosi_o address", 32'(spi_frame[23:16]), 32'(addr_for(p_axis)));

         wait_uart(base);
         if (timed_out)
            break;
         if (uart_q[base] !== p_hi)
            report_mismatch("tx_o first byte", 32'(uart_q[base]), 32'(p_hi));
         if (uart_q[base+1] !== p_lo)
            report_mismatch("tx_o second byte", 32'(uart_q[base+1]), 32'(p_lo));

         scan_display(p_exp);
         if (timed_out)
            break;
      end
      end_run();
   end

endmodule

/* testbench/sensor_patterns.txt */
// Columns: axis, low byte, high byte, expected sample (all hex)
// Axis 0 is X, 1 is Y, 2 is Z, 3 reads Z as well
0 34 12 1234
1 CD AB ABCD
2 00 00 0000
3 FF FF FFFF
0 0F F0 F00F
2 E5 07 07E5
3 9A 5C 5C9A
1 B6 D8 D8B6
1 01 80 8001

/* src.f */
+incdir+hw
hw/sensor_pkg.sv
hw/spi_if.sv
hw/spi_master.sv
hw/uart_tx.sv
hw/seg_display.sv
hw/sensor_ctrl.sv
hw/sensor_top.sv
testbench/adxl_model.sv
testbench/tb_sensor.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sensor
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
FAIL_MSG  ?= Test failures found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation finished without failures, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
